// ==== rvPkg.sv ====
package rvPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;      // register, ALU and data word
    typedef logic [4:0]      regAddr_t;   // x0 to x31
    typedef logic [XLEN-3:0] cacheAddr_t; // byte address without bits 1:0
    typedef logic [3:0]      aluCtrl_t;

    // alu operation codes
    localparam aluCtrl_t ALU_AND = 4'b0000;
    localparam aluCtrl_t ALU_OR  = 4'b0001;
    localparam aluCtrl_t ALU_ADD = 4'b0010;
    localparam aluCtrl_t ALU_SLL = 4'b0011;
    localparam aluCtrl_t ALU_SRL = 4'b0100;
    localparam aluCtrl_t ALU_SRA = 4'b0101;
    localparam aluCtrl_t ALU_SUB = 4'b0110;
    localparam aluCtrl_t ALU_SLT = 4'b0111;
    localparam aluCtrl_t ALU_XOR = 4'b1000;

    // rv32i major opcodes that the core executes
    localparam logic [6:0] OP_REG   = 7'b0110011; // add, sub, sll, ...
    localparam logic [6:0] OP_IMM   = 7'b0010011; // addi, slli, ...
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== pipeIf.sv ====
`timescale 1ns/1ns

// decode to execute stage register
interface decodeExIf;
    import rvPkg::*;

    regAddr_t   rs1;
    regAddr_t   rs2;
    regAddr_t   rd;
    word_t      rs1Val;
    word_t      rs2Val;
    word_t      imm;
    logic       aluSrc;    // operand b from imm
    logic       memRead;
    logic       memWrite;
    logic       regWrite;
    logic       memToReg;
    logic [3:0] funct;     // {funct7[5], funct3}
    logic       isReg;
    logic       isImm;

    modport producer (
        output rs1, rs2, rd, rs1Val, rs2Val, imm, aluSrc, memRead, memWrite,
               regWrite, memToReg, funct, isReg, isImm
    );

    modport consumer (
        input rs1, rs2, rd, rs1Val, rs2Val, imm, aluSrc, memRead, memWrite,
              regWrite, memToReg, funct, isReg, isImm
    );
endinterface

// execute to memory stage register
interface exMemIf;
    import rvPkg::*;

    word_t    aluResult;
    word_t    storeData;
    regAddr_t rd;
    logic     memRead;
    logic     memWrite;
    logic     regWrite;
    logic     memToReg;

    modport producer (output aluResult, storeData, rd, memRead, memWrite, regWrite, memToReg);
    modport consumer (input aluResult, storeData, rd, memRead, memWrite, regWrite, memToReg);
endinterface

// ==== regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic            clk,
    input  logic            rst_n,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    input  logic            wbEn,
    input  rvPkg::regAddr_t wbRd,
    input  rvPkg::word_t    wbData,
    output rvPkg::word_t    rs1Val,
    output rvPkg::word_t    rs2Val
);
    import rvPkg::*;

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    // same-cycle writeback goes straight through to the read port
    always_comb begin
        if (rs1 == '0) rs1Val = '0;
        else if (wbEn && wbRd == rs1) rs1Val = wbData;
        else rs1Val = regs[rs1];

        if (rs2 == '0) rs2Val = '0;
        else if (wbEn && wbRd == rs2) rs2Val = wbData;
        else rs2Val = regs[rs2];
    end

endmodule

// ==== fetchDecode.sv ====
`timescale 1ns/1ns

module fetchDecode #(
    parameter rvPkg::word_t ResetPc = 32'h0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rvPkg::word_t      iData,
    input  logic              dStall,
    input  logic              wbEn,
    input  rvPkg::regAddr_t   wbRd,
    input  rvPkg::word_t      wbData,
    output rvPkg::cacheAddr_t iAddr,
    decodeExIf.producer       dex
);
    import rvPkg::*;

    word_t      pc;
    word_t      instr;      // fetch/decode register
    logic [6:0] opcode;
    regAddr_t   rs1;
    regAddr_t   rs2;
    regAddr_t   rd;
    word_t      rs1Val;
    word_t      rs2Val;
    word_t      imm;
    logic       aluSrc;
    logic       memRead;
    logic       memWrite;
    logic       regWrite;
    logic       memToReg;
    logic       isReg;
    logic       isImm;
    logic       useRs1;
    logic       useRs2;
    logic       loadUse;
    logic       advance;

    assign iAddr = pc[XLEN-1:2];

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        {aluSrc, memRead, memWrite, regWrite, memToReg, isReg, isImm} = '0;
        case (opcode)
            OP_REG: begin
                regWrite = 1'b1;
                isReg    = 1'b1;
            end
            OP_IMM: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                isImm    = 1'b1;
            end
            OP_LOAD: begin
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            OP_STORE: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            default: ; // anything else is a nop
        endcase
    end

    // S format for stores, I format otherwise
    assign imm = memWrite ? {{20{instr[31]}}, instr[31:25], instr[11:7]}
                          : {{20{instr[31]}}, instr[31:20]};

    assign useRs1 = isReg | isImm | memRead | memWrite;
    assign useRs2 = isReg | memWrite;

    // load in execute feeding the instruction in decode
    assign loadUse = dex.memRead && dex.rd != '0 &&
                     ((useRs1 && dex.rd == rs1) || (useRs2 && dex.rd == rs2));

    assign advance = !dStall && !loadUse;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= ResetPc;
            instr <= NOP_INSTR;
        end else if (advance) begin
            pc    <= pc + 32'd4;
            instr <= iData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {dex.aluSrc, dex.memRead, dex.memWrite, dex.regWrite, dex.memToReg} <= '0;
            {dex.isReg, dex.isImm} <= '0;
        end else if (!dStall) begin
            if (loadUse) begin // bubble into execute
                {dex.aluSrc, dex.memRead, dex.memWrite, dex.regWrite, dex.memToReg} <= '0;
                {dex.isReg, dex.isImm} <= '0;
            end else begin
                dex.aluSrc   <= aluSrc;
                dex.memRead  <= memRead;
                dex.memWrite <= memWrite;
                dex.regWrite <= regWrite;
                dex.memToReg <= memToReg;
                dex.isReg    <= isReg;
                dex.isImm    <= isImm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!dStall) begin
            dex.rs1    <= rs1;
            dex.rs2    <= rs2;
            dex.rd     <= rd;
            dex.rs1Val <= rs1Val;
            dex.rs2Val <= rs2Val;
            dex.imm    <= imm;
            dex.funct  <= {instr[30], instr[14:12]};
        end
    end

    regFile i_regFile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val)
    );

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ns

module executeStage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dStall,
    input  logic            wbEn,
    input  rvPkg::regAddr_t wbRd,
    input  rvPkg::word_t    wbData,
    decodeExIf.consumer     dex,
    exMemIf.producer        exMem
);
    import rvPkg::*;

    word_t    opA;
    word_t    fwdB;     // rs2 after forwarding, also the store data
    word_t    opB;
    word_t    aluOut;
    aluCtrl_t aluCtrl;

    // memory stage beats writeback stage, x0 always from the register value
    function automatic word_t forwardOperand(regAddr_t src, word_t regVal);
        word_t val;
        val = regVal;
        if (wbEn && wbRd != '0 && wbRd == src) begin
            val = wbData;
        end
        if (exMem.regWrite && exMem.rd != '0 && exMem.rd == src) begin
            val = exMem.aluResult;
        end
        return val;
    endfunction

    always_comb begin
        opA  = forwardOperand(dex.rs1, dex.rs1Val);
        fwdB = forwardOperand(dex.rs2, dex.rs2Val);
    end

    assign opB = dex.aluSrc ? dex.imm : fwdB;

    always_comb begin
        aluCtrl = ALU_ADD; // lw/sw address
        if (dex.isReg || dex.isImm) begin
            case (dex.funct[2:0])
                3'b000:  aluCtrl = (dex.isReg && dex.funct[3]) ? ALU_SUB : ALU_ADD;
                3'b001:  aluCtrl = ALU_SLL;
                3'b010:  aluCtrl = ALU_SLT;
                3'b100:  aluCtrl = ALU_XOR;
                3'b101:  aluCtrl = dex.funct[3] ? ALU_SRA : ALU_SRL;
                3'b110:  aluCtrl = ALU_OR;
                3'b111:  aluCtrl = ALU_AND;
                default: aluCtrl = ALU_ADD; // sltu not supported
            endcase
        end
    end

    always_comb begin
        case (aluCtrl)
            ALU_AND: aluOut = opA & opB;
            ALU_OR:  aluOut = opA | opB;
            ALU_ADD: aluOut = opA + opB;
            ALU_SLL: aluOut = opA << opB[4:0];
            ALU_SRL: aluOut = opA >> opB[4:0];
            ALU_SRA: aluOut = word_t'($signed(opA) >>> opB[4:0]);
            ALU_SUB: aluOut = opA - opB;
            ALU_SLT: aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_XOR: aluOut = opA ^ opB;
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.regWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
        end else if (!dStall) begin
            exMem.memRead  <= dex.memRead;
            exMem.memWrite <= dex.memWrite;
            exMem.regWrite <= dex.regWrite;
            exMem.memToReg <= dex.memToReg;
        end
    end

    always_ff @(posedge clk) begin
        if (!dStall) begin
            exMem.aluResult <= aluOut;
            exMem.storeData <= fwdB;
            exMem.rd        <= dex.rd;
        end
    end

endmodule

// ==== memWriteback.sv ====
`timescale 1ns/1ns

module memWriteback (
    input  logic              clk,
    input  logic              rst_n,
    input  rvPkg::word_t      dRdata,
    input  logic              dStall,
    exMemIf.consumer          exMem,
    output logic              dRead,
    output logic              dWrite,
    output rvPkg::cacheAddr_t dAddr,
    output rvPkg::word_t      dWdata,
    output logic              wbEn,
    output rvPkg::regAddr_t   wbRd,
    output rvPkg::word_t      wbData
);
    import rvPkg::*;

    logic     mwRegWrite;
    logic     mwMemToReg;
    word_t    mwLoadData;
    word_t    mwAluResult;
    regAddr_t mwRd;

    // strobes stay up while the cache stalls
    assign dRead  = exMem.memRead;
    assign dWrite = exMem.memWrite;
    assign dAddr  = exMem.aluResult[XLEN-1:2];
    assign dWdata = exMem.storeData;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mwRegWrite <= 1'b0;
            mwMemToReg <= 1'b0;
        end else if (!dStall) begin
            mwRegWrite <= exMem.regWrite;
            mwMemToReg <= exMem.memToReg;
        end
    end

    always_ff @(posedge clk) begin
        if (!dStall) begin
            mwLoadData  <= dRdata;   // only meaningful for lw
            mwAluResult <= exMem.aluResult;
            mwRd        <= exMem.rd;
        end
    end

    assign wbEn   = mwRegWrite;
    assign wbRd   = mwRd;
    assign wbData = mwMemToReg ? mwLoadData : mwAluResult;

endmodule

// ==== rvPipeline.sv ====
`timescale 1ns/1ns

module rvPipeline #(
    parameter rvPkg::word_t ResetPc = 32'h0
) (
    input  logic              clk,
    input  logic              rst_n,
    output rvPkg::cacheAddr_t iAddr,
    input  rvPkg::word_t      iData,
    output logic              dRead,
    output logic              dWrite,
    output rvPkg::cacheAddr_t dAddr,
    output rvPkg::word_t      dWdata,
    input  rvPkg::word_t      dRdata,
    input  logic              dStall
);
    import rvPkg::*;

    logic     wbEn;
    regAddr_t wbRd;
    word_t    wbData;

    decodeExIf dex ();
    exMemIf    exMem ();

    fetchDecode #(
        .ResetPc (ResetPc)
    ) i_fetchDecode (
        .clk    (clk),
        .rst_n  (rst_n),
        .iData  (iData),
        .dStall (dStall),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData),
        .iAddr  (iAddr),
        .dex    (dex.producer)
    );

    executeStage i_executeStage (
        .clk    (clk),
        .rst_n  (rst_n),
        .dStall (dStall),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData),
        .dex    (dex.consumer),
        .exMem  (exMem.producer)
    );

    memWriteback i_memWriteback (
        .clk    (clk),
        .rst_n  (rst_n),
        .dRdata (dRdata),
        .dStall (dStall),
        .exMem  (exMem.consumer),
        .dRead  (dRead),
        .dWrite (dWrite),
        .dAddr  (dAddr),
        .dWdata (dWdata),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData)
    );

endmodule

// ==== tbRvPipeline.sv ====
`timescale 1ns/1ns

module tbRvPipeline;
    import rvPkg::*;

    localparam word_t      ResetPc   = 32'h0000_1000;
    localparam cacheAddr_t ResetWord = ResetPc[XLEN-1:2];
    localparam int         RandLen   = 48;   // random part of the program
    localparam int         ProgSlots = 64;
    localparam int         Timeout   = 3000;
    localparam logic [2:0] F3Table [8] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};

    logic        clk;
    logic        rst_n;
    logic        dRead;
    logic        dWrite;
    logic        dStall;
    cacheAddr_t  iAddr;
    cacheAddr_t  dAddr;
    cacheAddr_t  fetchIdx;
    word_t       iData;
    word_t       dWdata;
    word_t       dRdata;
    logic [31:0] lfsr;
    word_t       prog [ProgSlots];
    word_t       dataMem [128];
    cacheAddr_t  expAddr [$];   // expected stores in program order
    word_t       expData [$];
    int          storeIdx;

    rvPipeline #(
        .ResetPc (ResetPc)
    ) i_rvPipeline (
        .clk    (clk),
        .rst_n  (rst_n),
        .iAddr  (iAddr),
        .iData  (iData),
        .dRead  (dRead),
        .dWrite (dWrite),
        .dAddr  (dAddr),
        .dWdata (dWdata),
        .dRdata (dRdata),
        .dStall (dStall)
    );

    always #50 clk = ~clk;

    // instruction cache answers in the same cycle
    assign fetchIdx = iAddr - ResetWord;
    assign iData    = (fetchIdx < cacheAddr_t'(ProgSlots)) ? prog[fetchIdx[5:0]] : NOP_INSTR;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // rv32i result by funct3 and the bit 30 variant
    function automatic word_t isaAlu(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic abortRun();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkStoreAddr(string name, cacheAddr_t expected, cacheAddr_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkStoreData(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkFetchAddr(string name, cacheAddr_t expected, cacheAddr_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkStrobesIdle(string when);
        if (dRead !== 1'b0 || dWrite !== 1'b0) begin
            $display("a data cache strobe is high %s", when);
            abortRun();
        end
    endtask

    // random program and register dump go through the ISA model as they are built
    task automatic buildProgram();
        word_t       modelRegs [8];
        word_t       modelMem [16];
        regAddr_t    rd;
        regAddr_t    rs1;
        regAddr_t    rs2;
        regAddr_t    prevRd;
        logic [2:0]  sel;
        logic [2:0]  f3;
        logic [3:0]  pick;
        logic        alt;
        logic        isR;
        logic        forceDep;
        logic [11:0] imm;
        word_t       instr;
        word_t       res;
        modelRegs = '{default: '0};
        modelMem  = '{default: '0};
        prog      = '{default: NOP_INSTR};
        prevRd    = '0;
        forceDep  = 1'b0;
        for (int n = 0; n < RandLen; n++) begin
            sel = 3'(randBits(3));
            rd  = regAddr_t'(randBits(3));
            rs1 = (forceDep || randBits(1) == 32'd1) ? prevRd : regAddr_t'(randBits(3));
            rs2 = forceDep ? prevRd : regAddr_t'(randBits(3)); // lw result used right away
            forceDep = 1'b0;
            if (sel <= 3'd5) begin
                isR  = sel <= 3'd3;
                pick = isR ? 4'(randBits(4) % 9) : 4'(randBits(3));
                f3   = F3Table[pick[2:0]]; // sub shares funct3 with add
                alt  = pick == 4'd5 || pick == 4'd8; // sra/srai or sub
                if (isR) begin
                    instr = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, OP_REG};
                    res   = isaAlu(f3, alt, modelRegs[rs1[2:0]], modelRegs[rs2[2:0]]);
                end else begin
                    imm = (f3 == 3'b001 || f3 == 3'b101) ? {1'b0, alt, 5'd0, 5'(randBits(5))}
                                                         : 12'(randBits(12));
                    instr = {imm, rs1, f3, rd, OP_IMM};
                    res   = isaAlu(f3, alt, modelRegs[rs1[2:0]], {{20{imm[11]}}, imm});
                end
                prevRd = rd;
            end else begin
                imm = {6'd0, 4'(randBits(4)), 2'd0}; // x0 base and offset below 64
                if (sel == 3'd6) begin
                    instr    = {imm, 5'd0, 3'b010, rd, OP_LOAD};
                    res      = modelMem[imm[5:2]];
                    prevRd   = rd;
                    forceDep = 1'b1;
                end else begin
                    instr = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};
                    modelMem[imm[5:2]] = modelRegs[rs2[2:0]];
                    expAddr.push_back(cacheAddr_t'(imm[11:2]));
                    expData.push_back(modelRegs[rs2[2:0]]);
                end
            end
            if (sel != 3'd7 && rd != '0) begin
                modelRegs[rd[2:0]] = res;
            end
            prog[6'(n)] = instr;
        end
        for (int r = 1; r < 8; r++) begin
            imm = 12'(256 + 4 * (r - 1));
            prog[6'(RandLen + r - 1)] = {imm[11:5], 5'(r), 5'd0, 3'b010, imm[4:0], OP_STORE};
            expAddr.push_back(cacheAddr_t'(imm[11:2]));
            expData.push_back(modelRegs[3'(r)]);
        end
    endtask

    task automatic waitStores();
        int cycles;
        cycles = 0;
        while (storeIdx < expAddr.size()) begin
            @(posedge clk);
            cycles++;
            if (cycles >= Timeout) begin
                $display("timeout with %0d of %0d stores committed", storeIdx, expAddr.size());
                abortRun();
            end
        end
    endtask

    // data cache stalls about a quarter of the strobed cycles
    always @(posedge clk) begin
        string tag;
        #1;
        dStall = (dRead || dWrite) && randBits(2) == 32'd0;
        // read data only valid for a taken read
        dRdata = (dRead && !dStall) ? dataMem[dAddr[6:0]] : ~dataMem[dAddr[6:0]];
        if (dWrite && !dStall) begin
            if (storeIdx >= expAddr.size()) begin
                $display("store to word %h committed after the last expected store", dAddr);
                abortRun();
            end else begin
                tag = $sformatf("store %0d", storeIdx);
                checkStoreAddr({tag, " address"}, expAddr[storeIdx], dAddr);
                checkStoreData({tag, " data"}, expData[storeIdx], dWdata);
                dataMem[dAddr[6:0]] = dWdata;
                storeIdx++;
            end
        end
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        dStall   = 1'b0;
        dRdata   = '0;
        storeIdx = 0;
        lfsr     = 32'hde558bb9;
        dataMem  = '{default: '0};
        buildProgram();
        repeat (4) begin
            @(posedge clk);
            #1;
            checkStrobesIdle("during reset");
            checkFetchAddr("fetch during reset", ResetWord, iAddr);
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        checkStrobesIdle("just after reset");
        checkFetchAddr("first fetch after reset", ResetWord + 30'd1, iAddr);
        waitStores();
        repeat (10) @(posedge clk); // a repeated store would show up here
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
rvPkg.sv
pipeIf.sv
regFile.sv
fetchDecode.sv
executeStage.sv
memWriteback.sv
rvPipeline.sv
tbRvPipeline.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f build.f --top-module tbRvPipeline -o simRvPipeline
out=$(./obj_dir/simRvPipeline || true)
echo "$out"
echo "$out" | grep -q "all tests passed"
